// ==== include/execVectors.svh ====
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

typedef struct packed {
    logic [mipsExecPkg::THREAD_W-1:0] thread;
    logic [31:0]                      instr;
    logic [31:0]                      rsData;
    logic [31:0]                      rtData;
    logic [31:0]                      expData;
    logic                             expWrite;
} vecT;

// rs=1 rt=2 rd=3, register numbers are don't-care here
function automatic logic [31:0] rInstr(logic [5:0] fn, logic [4:0] sa);
    return {mipsExecPkg::OP_RTYPE, 5'd1, 5'd2, 5'd3, sa, fn};
endfunction

function automatic logic [31:0] iInstr(logic [5:0] op, logic [15:0] imm);
    return {op, 5'd1, 5'd3, imm};
endfunction

function automatic vecT mkVec(int th, logic [31:0] ins, logic [31:0] rs, logic [31:0] rt);
    vecT v;
    v        = '0;
    v.thread = th[mipsExecPkg::THREAD_W-1:0];
    v.instr  = ins;
    v.rsData = rs;
    v.rtData = rt;
    return v;
endfunction

// expected GPR result, updates this thread's HI/LO model
function automatic void refModel(inout vecT v, inout logic [31:0] hi, inout logic [31:0] lo);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] zImm;
    logic [4:0]  sa;
    a    = v.rsData;
    b    = v.rtData;
    sa   = v.instr[10:6];
    sImm = {{16{v.instr[15]}}, v.instr[15:0]};
    zImm = {16'b0, v.instr[15:0]};
    v.expData  = '0;
    v.expWrite = 1'b1;
    case (v.instr[31:26])
        mipsExecPkg::OP_ADDIU: v.expData = a + sImm;
        mipsExecPkg::OP_SLTI:  v.expData = {31'b0, $signed(a) < $signed(sImm)};
        mipsExecPkg::OP_SLTIU: v.expData = {31'b0, a < sImm};
        mipsExecPkg::OP_ANDI:  v.expData = a & zImm;
        mipsExecPkg::OP_ORI:   v.expData = a | zImm;
        mipsExecPkg::OP_XORI:  v.expData = a ^ zImm;
        mipsExecPkg::OP_RTYPE: begin
            case (v.instr[5:0])
                mipsExecPkg::FN_ADDU: v.expData = a + b;
                mipsExecPkg::FN_SUBU: v.expData = a - b;
                mipsExecPkg::FN_AND:  v.expData = a & b;
                mipsExecPkg::FN_OR:   v.expData = a | b;
                mipsExecPkg::FN_XOR:  v.expData = a ^ b;
                mipsExecPkg::FN_SLL:  v.expData = b << sa;
                mipsExecPkg::FN_SRL:  v.expData = b >> sa;
                mipsExecPkg::FN_SRA:  v.expData = $signed(b) >>> sa;
                mipsExecPkg::FN_SLLV: v.expData = b << a[4:0];
                mipsExecPkg::FN_SRLV: v.expData = b >> a[4:0];
                mipsExecPkg::FN_SRAV: v.expData = $signed(b) >>> a[4:0];
                mipsExecPkg::FN_SLT:  v.expData = {31'b0, $signed(a) < $signed(b)};
                mipsExecPkg::FN_SLTU: v.expData = {31'b0, a < b};
                mipsExecPkg::FN_MFHI: v.expData = hi;
                mipsExecPkg::FN_MFLO: v.expData = lo;
                default: begin
                    v.expWrite = 1'b0;
                    case (v.instr[5:0])
                        mipsExecPkg::FN_MTHI:  hi = a;
                        mipsExecPkg::FN_MTLO:  lo = a;
                        mipsExecPkg::FN_MULT:
                            {hi, lo} = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                        mipsExecPkg::FN_MULTU: {hi, lo} = {32'b0, a} * {32'b0, b};
                        mipsExecPkg::FN_DIV: begin
                            if (b == 32'd0) begin
                                hi = a;
                                lo = '1;
                            end else if (a == 32'h8000_0000 && b == '1) begin
                                hi = '0;
                                lo = a;
                            end else begin
                                hi = $signed(a) % $signed(b);
                                lo = $signed(a) / $signed(b);
                            end
                        end
                        mipsExecPkg::FN_DIVU: begin
                            hi = (b == 32'd0) ? a : a % b;
                            lo = (b == 32'd0) ? '1 : a / b;
                        end
                        default: hi = hi;
                    endcase
                end
            endcase
        end
        default: v.expWrite = 1'b0;
    endcase
endfunction

// fixed entries first, then random ones, then run the model over the lot
function automatic void buildVectors(ref vecT tbl[$]);
    integer      seed;
    int          idx;
    logic [31:0] pool[$];
    logic [31:0] hi [mipsExecPkg::THREADS];
    logic [31:0] lo [mipsExecPkg::THREADS];
    logic [31:0] mfhi;
    logic [31:0] mflo;
    vecT         v;
    seed = 32'ha70a;
    mfhi = rInstr(mipsExecPkg::FN_MFHI, 5'd0);
    mflo = rInstr(mipsExecPkg::FN_MFLO, 5'd0);
    tbl.delete();
    pool = '{rInstr(mipsExecPkg::FN_ADDU, 5'd0), iInstr(mipsExecPkg::OP_ADDIU, 16'hfff0),
             rInstr(mipsExecPkg::FN_SUBU, 5'd0), rInstr(mipsExecPkg::FN_AND, 5'd0),
             iInstr(mipsExecPkg::OP_ANDI, 16'h8001), rInstr(mipsExecPkg::FN_OR, 5'd0),
             iInstr(mipsExecPkg::OP_ORI, 16'hf00f), rInstr(mipsExecPkg::FN_XOR, 5'd0),
             iInstr(mipsExecPkg::OP_XORI, 16'hffff), rInstr(mipsExecPkg::FN_SLL, 5'd5),
             rInstr(mipsExecPkg::FN_SRL, 5'd13), rInstr(mipsExecPkg::FN_SRA, 5'd31),
             rInstr(mipsExecPkg::FN_SLLV, 5'd0), rInstr(mipsExecPkg::FN_SRLV, 5'd0),
             rInstr(mipsExecPkg::FN_SRAV, 5'd0), rInstr(mipsExecPkg::FN_SLT, 5'd0),
             rInstr(mipsExecPkg::FN_SLTU, 5'd0), iInstr(mipsExecPkg::OP_SLTI, 16'h8000),
             iInstr(mipsExecPkg::OP_SLTIU, 16'h8000), rInstr(mipsExecPkg::FN_MULT, 5'd0),
             mfhi, mflo, rInstr(mipsExecPkg::FN_MULTU, 5'd0), mfhi, mflo,
             rInstr(mipsExecPkg::FN_DIV, 5'd0), mfhi, mflo,
             rInstr(mipsExecPkg::FN_DIVU, 5'd0), mfhi, mflo,
             rInstr(mipsExecPkg::FN_MTHI, 5'd0), rInstr(mipsExecPkg::FN_MTLO, 5'd0), mfhi, mflo,
             rInstr(6'h3f, 5'd0), iInstr(6'h3f, 16'h1234)};
    // HI/LO read back zero right after reset
    for (int t = 0; t < mipsExecPkg::THREADS; t++) begin
        tbl.push_back(mkVec(t, mfhi, 32'd0, 32'd0));
        tbl.push_back(mkVec(t, mflo, 32'd0, 32'd0));
    end
    // operand signs differ, rs[4:0] = 20 with upper bits set
    foreach (pool[i]) tbl.push_back(mkVec(0, pool[i], 32'h8000_00f4, 32'h1234_5678));
    // negative rt so sra and srav must shift in ones
    tbl.push_back(mkVec(0, rInstr(mipsExecPkg::FN_SRA, 5'd4), 32'd0, 32'h8765_4321));
    tbl.push_back(mkVec(0, rInstr(mipsExecPkg::FN_SRAV, 5'd0), 32'hffff_ffe4, 32'h8765_4321));
    // rs of zero tells a sign-extended slti immediate from a zero-extended one
    tbl.push_back(mkVec(0, iInstr(mipsExecPkg::OP_SLTI, 16'h8000), 32'd0, 32'd0));
    // divide corners, then HI/LO isolation between threads
    tbl.push_back(mkVec(1, rInstr(mipsExecPkg::FN_DIV, 5'd0), 32'd17, 32'd0));
    tbl.push_back(mkVec(2, rInstr(mipsExecPkg::FN_DIV, 5'd0), 32'h8000_0000, '1));
    tbl.push_back(mkVec(3, rInstr(mipsExecPkg::FN_DIVU, 5'd0), 32'hdead_beef, 32'd0));
    tbl.push_back(mkVec(1, mfhi, 32'd0, 32'd0));
    tbl.push_back(mkVec(2, mflo, 32'd0, 32'd0));
    tbl.push_back(mkVec(3, mflo, 32'd0, 32'd0));
    tbl.push_back(mkVec(2, rInstr(mipsExecPkg::FN_MTHI, 5'd0), 32'hcafe_f00d, 32'd0));
    tbl.push_back(mkVec(3, rInstr(mipsExecPkg::FN_MTLO, 5'd0), 32'h0bad_cafe, 32'd0));
    for (int t = 0; t < mipsExecPkg::THREADS; t++) begin
        tbl.push_back(mkVec(t, mfhi, 32'd0, 32'd0));
        tbl.push_back(mkVec(t, mflo, 32'd0, 32'd0));
    end
    // random back-to-back traffic over all threads
    for (int i = 0; i < 96; i++) begin
        idx = $unsigned($random(seed)) % pool.size();
        tbl.push_back(mkVec($random(seed), pool[idx], $random(seed), $random(seed)));
    end
    foreach (hi[t]) begin
        hi[t] = '0;
        lo[t] = '0;
    end
    foreach (tbl[i]) begin
        v = tbl[i];
        refModel(v, hi[v.thread], lo[v.thread]);
        tbl[i] = v;
    end
endfunction

`endif

// ==== bench/execTb.sv ====
`timescale 1ns/10ps

module execTb;

    `include "execVectors.svh"

    logic                 clk;
    logic                 rstN;
    logic                 issueValid;
    mipsExecPkg::issueT   issue;
    logic                 resultValid;
    mipsExecPkg::execOutT result;

    // stimulus table, expected outputs and their due cycles
    vecT                  vectors[$];
    mipsExecPkg::execOutT expQ[$];
    int                   dueQ[$];
    int                   cycles = 0;
    int                   checked = 0;
    int                   limitCycles = 0;

    mipsExecTop mipsExecTop_i (
        .clk         (clk),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .issue       (issue),
        .resultValid (resultValid),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun(string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic reportMismatch(string sigName, logic [31:0] got, logic [31:0] want);
        stopRun($sformatf("[FAIL] %0t %s got %h expected %h", $time, sigName, got, want));
    endtask

    // compare one output against the oldest outstanding issue
    task automatic checkResult();
        mipsExecPkg::execOutT want;
        int                   due;
        assert (expQ.size() != 0)
            else stopRun("a result came out with no instruction outstanding");
        want = expQ.pop_front();
        due  = dueQ.pop_front();
        assert (result.data == want.data)
            else reportMismatch("result.data", result.data, want.data);
        assert (result.regWrite == want.regWrite)
            else reportMismatch("result.regWrite", 32'(result.regWrite), 32'(want.regWrite));
        assert (result.thread == want.thread)
            else reportMismatch("result.thread", 32'(result.thread), 32'(want.thread));
        // fixed three-cycle latency
        assert (cycles == due)
            else reportMismatch("result arrival cycle", 32'(cycles), 32'(due));
        checked++;
    endtask

    // cycle counter doubles as the run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limitCycles > 0 && cycles >= limitCycles) begin
            stopRun("timeout: results did not drain within the cycle limit");
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (resultValid) begin
            checkResult();
        end
    end

    initial begin
        rstN       = 1'b0;
        issueValid = 1'b0;
        issue      = '0;
        buildVectors(vectors);
        limitCycles = vectors.size() + 3 + 20;
        repeat (2) @(posedge clk);
        #2 rstN = 1'b1;
        // idle cycles, nothing may come out
        repeat (3) @(posedge clk);
        foreach (vectors[i]) begin
            @(posedge clk);
            #2;
            issueValid    = 1'b1;
            issue.instr   = vectors[i].instr;
            issue.rsData  = vectors[i].rsData;
            issue.rtData  = vectors[i].rtData;
            issue.thread  = vectors[i].thread;
            expQ.push_back('{data: vectors[i].expData, regWrite: vectors[i].expWrite,
                             thread: vectors[i].thread});
            dueQ.push_back(cycles + 3);
        end
        @(posedge clk);
        #2 issueValid = 1'b0;
        issue = '0;
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        // a few quiet cycles to catch stray results
        repeat (3) @(posedge clk);
        if (checked != vectors.size()) begin
            stopRun($sformatf("checked %0d results but issued %0d instructions",
                              checked, vectors.size()));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

// ==== design/aluLane.sv ====
`timescale 1ns/10ps

module aluLane (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   reqValid,
    input  mipsExecPkg::laneReqT   req,
    output logic                   resValid,
    output mipsExecPkg::laneResT   res
);

    logic [31:0]        rs;
    logic [31:0]        rt;
    logic [31:0]        hiReg;
    logic [31:0]        loReg;
    logic [31:0]        nextHi;
    logic [31:0]        nextLo;
    logic [31:0]        result;
    logic               writeGpr;
    logic signed [63:0] sProd;
    logic [63:0]        uProd;
    logic [31:0]        sQuot;
    logic [31:0]        sRem;
    logic [31:0]        uQuot;
    logic [31:0]        uRem;

    assign rs = req.rsData;
    assign rt = req.rtData;

    // full-width products
    always_comb begin
        sProd = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
        uProd = {32'b0, rs} * {32'b0, rt};
    end

    // single-cycle divide with the MIPS corner cases pinned down
    always_comb begin
        if (rt == 32'd0) begin
            // zero divisor
            uQuot = '1;
            uRem  = rs;
            sQuot = '1;
            sRem  = rs;
        end else begin
            uQuot = rs / rt;
            uRem  = rs % rt;
            if (rs == 32'h8000_0000 && rt == 32'hffff_ffff) begin
                // most negative / -1 wraps back to the dividend
                sQuot = rs;
                sRem  = 32'd0;
            end else begin
                sQuot = $signed(rs) / $signed(rt);
                sRem  = $signed(rs) % $signed(rt);
            end
        end
    end

    always_comb begin
        result   = 32'd0;
        writeGpr = 1'b1;
        nextHi   = hiReg;
        nextLo   = loReg;
        case (req.op)
            mipsExecPkg::opAddu:  result = rs + rt;
            mipsExecPkg::opAddiu: result = rs + req.imm32;
            mipsExecPkg::opSubu:  result = rs - rt;
            mipsExecPkg::opAnd:   result = rs & rt;
            mipsExecPkg::opAndi:  result = rs & req.imm32;
            mipsExecPkg::opOr:    result = rs | rt;
            mipsExecPkg::opOri:   result = rs | req.imm32;
            mipsExecPkg::opXor:   result = rs ^ rt;
            mipsExecPkg::opXori:  result = rs ^ req.imm32;
            mipsExecPkg::opSll:   result = rt << req.sa;
            mipsExecPkg::opSrl:   result = rt >> req.sa;
            mipsExecPkg::opSra:   result = $signed(rt) >>> req.sa;
            // variable shifts take rs[4:0] only
            mipsExecPkg::opSllv:  result = rt << rs[4:0];
            mipsExecPkg::opSrlv:  result = rt >> rs[4:0];
            mipsExecPkg::opSrav:  result = $signed(rt) >>> rs[4:0];
            mipsExecPkg::opSlt:   result = {31'b0, $signed(rs) < $signed(rt)};
            mipsExecPkg::opSlti:  result = {31'b0, $signed(rs) < $signed(req.imm32)};
            mipsExecPkg::opSltu:  result = {31'b0, rs < rt};
            // sign-extended imm, compared unsigned
            mipsExecPkg::opSltiu: result = {31'b0, rs < req.imm32};
            mipsExecPkg::opMfhi:  result = hiReg;
            mipsExecPkg::opMflo:  result = loReg;
            mipsExecPkg::opMult: begin
                {nextHi, nextLo} = sProd;
                writeGpr         = 1'b0;
            end
            mipsExecPkg::opMultu: begin
                {nextHi, nextLo} = uProd;
                writeGpr         = 1'b0;
            end
            // quotient to LO, remainder to HI
            mipsExecPkg::opDiv: begin
                nextHi   = sRem;
                nextLo   = sQuot;
                writeGpr = 1'b0;
            end
            mipsExecPkg::opDivu: begin
                nextHi   = uRem;
                nextLo   = uQuot;
                writeGpr = 1'b0;
            end
            mipsExecPkg::opMthi: begin
                nextHi   = rs;
                writeGpr = 1'b0;
            end
            mipsExecPkg::opMtlo: begin
                nextLo   = rs;
                writeGpr = 1'b0;
            end
            default:              writeGpr = 1'b0;
        endcase
    end

    // HI/LO are architectural, cleared on reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiReg    <= 32'd0;
            loReg    <= 32'd0;
            resValid <= 1'b0;
        end else begin
            resValid <= reqValid;
            if (reqValid) begin
                hiReg <= nextHi;
                loReg <= nextLo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            res.data     <= result;
            res.regWrite <= writeGpr;
        end
    end

    // dispatcher clears shamt for everything but sll/srl/sra
    nopNoShift: assert property (@(posedge clk) disable iff (!rstN)
        reqValid && req.op == mipsExecPkg::opNop |-> req.sa == 5'd0)
        else $error("nop request carries a shift amount");

endmodule

// ==== design/mipsExecPkg.sv ====
package mipsExecPkg;

    // thread and datapath sizing
    localparam int THREADS  = 4;
    localparam int THREAD_W = 2;
    localparam int XLEN     = 32;

    // major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;

    // funct field, R-type only
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_SLLV  = 6'h04;
    localparam logic [5:0] FN_SRLV  = 6'h06;
    localparam logic [5:0] FN_SRAV  = 6'h07;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    // opNop stays at zero, unknown words decode to it
    typedef enum logic [4:0] {
        opNop, opAddu, opAddiu, opSubu,
        opAnd, opAndi, opOr, opOri, opXor, opXori,
        opSll, opSrl, opSra, opSllv, opSrlv, opSrav,
        opSlt, opSlti, opSltu, opSltiu,
        opMult, opMultu, opDiv, opDivu,
        opMfhi, opMflo, opMthi, opMtlo
    } aluOpT;

    typedef struct packed {
        logic [31:0]         instr;
        logic [XLEN-1:0]     rsData;
        logic [XLEN-1:0]     rtData;
        logic [THREAD_W-1:0] thread;
    } issueT;

    typedef struct packed {
        aluOpT           op;
        logic [XLEN-1:0] rsData;
        logic [XLEN-1:0] rtData;
        // already sign or zero extended
        logic [XLEN-1:0] imm32;
        logic [4:0]      sa;
    } laneReqT;

    typedef struct packed {
        logic [XLEN-1:0] data;
        logic            regWrite;
    } laneResT;

    typedef struct packed {
        logic [XLEN-1:0]     data;
        logic                regWrite;
        logic [THREAD_W-1:0] thread;
    } execOutT;

endpackage

// ==== design/mipsExecTop.sv ====
`timescale 1ns/10ps

module mipsExecTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    issueValid,
    input  mipsExecPkg::issueT      issue,
    output logic                    resultValid,
    output mipsExecPkg::execOutT    result
);

    logic [mipsExecPkg::THREADS-1:0] laneValid;
    logic [mipsExecPkg::THREADS-1:0] resValid;
    mipsExecPkg::laneReqT            laneReq;
    mipsExecPkg::laneResT            laneRes [mipsExecPkg::THREADS];

    opDispatcher opDispatcher_i (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .issue      (issue),
        .laneValid  (laneValid),
        .laneReq    (laneReq)
    );

    // one lane per hardware thread, each with private HI/LO
    for (genvar k = 0; k < mipsExecPkg::THREADS; k++) begin : lanes
        aluLane aluLane_i (
            .clk      (clk),
            .rstN     (rstN),
            .reqValid (laneValid[k]),
            .req      (laneReq),
            .resValid (resValid[k]),
            .res      (laneRes[k])
        );
    end

    resultCollector resultCollector_i (
        .clk         (clk),
        .rstN        (rstN),
        .resValid    (resValid),
        .laneRes     (laneRes),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// ==== design/opDispatcher.sv ====
`timescale 1ns/10ps

module opDispatcher (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             issueValid,
    input  mipsExecPkg::issueT               issue,
    output logic [mipsExecPkg::THREADS-1:0]  laneValid,
    output mipsExecPkg::laneReqT             laneReq
);

    logic [5:0]                         opcode;
    logic [5:0]                         funct;
    logic [15:0]                        imm;
    logic                               zeroExt;
    mipsExecPkg::aluOpT                 op;
    mipsExecPkg::laneReqT               nextReq;
    logic [mipsExecPkg::THREADS-1:0]    nextValid;

    // instruction fields
    assign opcode = issue.instr[31:26];
    assign funct  = issue.instr[5:0];
    assign imm    = issue.instr[15:0];

    // logical immediates zero extend, everything else sign extends
    assign zeroExt = (opcode == mipsExecPkg::OP_ANDI) || (opcode == mipsExecPkg::OP_ORI) ||
                     (opcode == mipsExecPkg::OP_XORI);

    always_comb begin
        op = mipsExecPkg::opNop;
        if (opcode == mipsExecPkg::OP_RTYPE) begin
            case (funct)
                mipsExecPkg::FN_ADDU:  op = mipsExecPkg::opAddu;
                mipsExecPkg::FN_SUBU:  op = mipsExecPkg::opSubu;
                mipsExecPkg::FN_AND:   op = mipsExecPkg::opAnd;
                mipsExecPkg::FN_OR:    op = mipsExecPkg::opOr;
                mipsExecPkg::FN_XOR:   op = mipsExecPkg::opXor;
                mipsExecPkg::FN_SLL:   op = mipsExecPkg::opSll;
                mipsExecPkg::FN_SRL:   op = mipsExecPkg::opSrl;
                mipsExecPkg::FN_SRA:   op = mipsExecPkg::opSra;
                mipsExecPkg::FN_SLLV:  op = mipsExecPkg::opSllv;
                mipsExecPkg::FN_SRLV:  op = mipsExecPkg::opSrlv;
                mipsExecPkg::FN_SRAV:  op = mipsExecPkg::opSrav;
                mipsExecPkg::FN_SLT:   op = mipsExecPkg::opSlt;
                mipsExecPkg::FN_SLTU:  op = mipsExecPkg::opSltu;
                mipsExecPkg::FN_MULT:  op = mipsExecPkg::opMult;
                mipsExecPkg::FN_MULTU: op = mipsExecPkg::opMultu;
                mipsExecPkg::FN_DIV:   op = mipsExecPkg::opDiv;
                mipsExecPkg::FN_DIVU:  op = mipsExecPkg::opDivu;
                mipsExecPkg::FN_MFHI:  op = mipsExecPkg::opMfhi;
                mipsExecPkg::FN_MFLO:  op = mipsExecPkg::opMflo;
                mipsExecPkg::FN_MTHI:  op = mipsExecPkg::opMthi;
                mipsExecPkg::FN_MTLO:  op = mipsExecPkg::opMtlo;
                default:               op = mipsExecPkg::opNop;
            endcase
        end else begin
            case (opcode)
                mipsExecPkg::OP_ADDIU: op = mipsExecPkg::opAddiu;
                mipsExecPkg::OP_SLTI:  op = mipsExecPkg::opSlti;
                mipsExecPkg::OP_SLTIU: op = mipsExecPkg::opSltiu;
                mipsExecPkg::OP_ANDI:  op = mipsExecPkg::opAndi;
                mipsExecPkg::OP_ORI:   op = mipsExecPkg::opOri;
                mipsExecPkg::OP_XORI:  op = mipsExecPkg::opXori;
                default:               op = mipsExecPkg::opNop;
            endcase
        end
    end

    always_comb begin
        nextReq.op     = op;
        nextReq.rsData = issue.rsData;
        nextReq.rtData = issue.rtData;
        nextReq.imm32  = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
        // shamt only matters for the fixed shifts, zero it elsewhere
        if (op == mipsExecPkg::opSll || op == mipsExecPkg::opSrl || op == mipsExecPkg::opSra) begin
            nextReq.sa = issue.instr[10:6];
        end else begin
            nextReq.sa = 5'd0;
        end
        // one-hot strobe toward the owning lane
        for (int k = 0; k < mipsExecPkg::THREADS; k++) begin
            nextValid[k] = issueValid && (issue.thread == k[mipsExecPkg::THREAD_W-1:0]);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            laneValid <= '0;
        end else begin
            laneValid <= nextValid;
        end
    end

    // shared request bus, lanes qualify it with their strobe
    always_ff @(posedge clk) begin
        if (issueValid) begin
            laneReq <= nextReq;
        end
    end

    laneOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(laneValid))
        else $error("more than one lane strobed");

endmodule

// ==== design/resultCollector.sv ====
`timescale 1ns/10ps

module resultCollector (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [mipsExecPkg::THREADS-1:0]  resValid,
    input  mipsExecPkg::laneResT             laneRes [mipsExecPkg::THREADS],
    output logic                             resultValid,
    output mipsExecPkg::execOutT             result
);

    mipsExecPkg::execOutT picked;

    // at most one lane finishes per cycle, its index is the thread
    always_comb begin
        picked = '0;
        for (int k = 0; k < mipsExecPkg::THREADS; k++) begin
            if (resValid[k]) begin
                picked.data     = laneRes[k].data;
                picked.regWrite = laneRes[k].regWrite;
                picked.thread   = k[mipsExecPkg::THREAD_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= |resValid;
        end
    end

    always_ff @(posedge clk) begin
        if (|resValid) begin
            result <= picked;
        end
    end

    resOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(resValid))
        else $error("two lanes finished in one cycle");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, then run; a $fatal gives a non-zero exit
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module execTb -o execSim \
    && ./obj_dir/execSim \
    && echo "simulation exited cleanly" \
    || { echo "simulation or build returned an error status" >&2; exit 1; }

// ==== sources.f ====
+incdir+include
design/mipsExecPkg.sv
design/opDispatcher.sv
design/aluLane.sv
design/resultCollector.sv
design/mipsExecTop.sv
bench/execTb.sv
